// ==== rtl/dds_defines.svh ====
// ------------------
// width, channel count and pipeline depth macros for the multichannel DDS
// ------------------
`ifndef DDS_DEFINES_SVH
`define DDS_DEFINES_SVH

// phase accumulator width
`define DDS_PHASE_BITS 24
// low phase bits dropped before the table lookup
`define DDS_QUANT_BITS 14
// signed cosine sample width
`define DDS_SAMPLE_WIDTH 18
// samples per output word
`define DDS_PARALLEL 4
// independent channels
`define DDS_CHANNELS 2
// phase register, table read, fold and output register
`define DDS_PIPE_DEPTH 3

`endif

// ==== rtl/dds_pkg.sv ====
// ------------------
// phase, address and sample types, port structs
// ------------------
`include "dds_defines.svh"

package dds_pkg;

  // accumulator phase, wraps at 2^PHASE_BITS
  typedef logic [`DDS_PHASE_BITS-1:0] phase_t;

  // truncated phase used as table address
  typedef logic [`DDS_PHASE_BITS-`DDS_QUANT_BITS-1:0] lut_addr_t;

  // two's complement cosine sample
  typedef logic signed [`DDS_SAMPLE_WIDTH-1:0] sample_t;

  // one output word, samples[0] is first in time
  typedef struct packed {
    sample_t [`DDS_PARALLEL-1:0] samples;
  } word_t;

  // one increment per channel, channel 0 in the low bits
  typedef struct packed {
    phase_t [`DDS_CHANNELS-1:0] inc;
  } phase_inc_t;

  // per channel output, valid qualifies the word
  typedef struct packed {
    logic  valid;
    word_t word;
  } chan_out_t;

endpackage

// ==== rtl/dds_phase_accum.sv ====
// ------------------
// phase accumulator producing the phases of one parallel word
// ------------------
`timescale 1ns/1ps
`include "dds_defines.svh"

module dds_phase_accum
  import dds_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   phase_inc_valid,
  input  phase_t phase_inc,
  input  logic   advance,
  output phase_t phases [`DDS_PARALLEL]
);

  // inc_mult[j] holds (j + 1) times the increment in force
  // inc_mult[0] is the increment itself
  phase_t inc_mult [`DDS_PARALLEL];

  // phase of sample 0 of the next word
  phase_t base;

  // multiples are formed once per load so the per-word adders stay
  // two-input
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int j = 0; j < `DDS_PARALLEL; j++) begin
        inc_mult[j] <= '0;
      end
    end else if (phase_inc_valid) begin
      for (int j = 0; j < `DDS_PARALLEL; j++) begin
        inc_mult[j] <= phase_t'(j + 1) * phase_inc;
      end
    end
  end

  // base steps by PARALLEL increments per generated word
  always_ff @(posedge clk) begin
    if (reset) begin
      base <= '0;
    end else if (advance) begin
      base <= base + inc_mult[`DDS_PARALLEL-1];
    end
  end

  // stage 1 phase register, holds while the pipeline is stalled
  always_ff @(posedge clk) begin
    if (advance) begin
      phases[0] <= base;
      for (int j = 1; j < `DDS_PARALLEL; j++) begin
        phases[j] <= base + inc_mult[j-1];
      end
    end
  end

endmodule

// ==== rtl/dds_cos_lut.sv ====
// ------------------
// quarter-wave cosine table with
// quadrant folding, two registered stages
// ------------------
`timescale 1ns/1ps
`include "dds_defines.svh"

module dds_cos_lut
  import dds_pkg::*;
(
  input  logic    clk,
  input  logic    enable,
  input  phase_t  phase,
  output sample_t sample
);

  localparam int ADDR_BITS = $bits(lut_addr_t);
  localparam int QUARTER_BITS = ADDR_BITS - 2;
  localparam int QUARTER_DEPTH = 2 ** QUARTER_BITS;
  localparam int FULL_DEPTH = 2 ** ADDR_BITS;

  // peak amplitude, leaves half an lsb of headroom at full scale
  localparam real AMPL = (2.0 ** (`DDS_SAMPLE_WIDTH - 1)) - 0.5;
  localparam real PI = 3.14159265358979323846;

  // mirrored index needs one extra bit for the zero crossing
  localparam logic [QUARTER_BITS:0] MIRROR_BASE = (QUARTER_BITS + 1)'(QUARTER_DEPTH);

  sample_t quarter [QUARTER_DEPTH];

  lut_addr_t                addr;
  logic [1:0]               quadrant;
  logic [QUARTER_BITS-1:0]  index;
  logic [QUARTER_BITS:0]    mirror_idx;

  // stage 2 registers
  logic [QUARTER_BITS:0]    mirror_idx_q;
  logic [1:0]               quadrant_q;

  // first quadrant only, rounded as floor(ampl * cos - 0.5)
  initial begin
    for (int i = 0; i < QUARTER_DEPTH; i++) begin
      quarter[i] = sample_t'($rtoi($floor(
        AMPL * $cos(2.0 * PI * real'(i) / real'(FULL_DEPTH)) - 0.5)));
    end
  end

  always_comb begin
    addr = phase[`DDS_PHASE_BITS-1 -: ADDR_BITS];
    quadrant = addr[ADDR_BITS-1 -: 2];
    index = addr[QUARTER_BITS-1:0];
    // quadrants 1 and 3 run backwards through the table
    if (quadrant[0]) begin
      mirror_idx = MIRROR_BASE - {1'b0, index};
    end else begin
      mirror_idx = {1'b0, index};
    end
  end

  always_ff @(posedge clk) begin
    if (enable) begin
      mirror_idx_q <= mirror_idx;
      quadrant_q <= quadrant;
    end
  end

  // stage 3: read, fold sign, register
  always_ff @(posedge clk) begin
    if (enable) begin
      if (mirror_idx_q[QUARTER_BITS]) begin
        // pi/2 and 3pi/2 sit just past the table, floor(-0.5) is -1
        sample <= '1;
      end else if (quadrant_q[1] ^ quadrant_q[0]) begin
        // quadrants 1 and 2 are negative, inversion keeps the rounding
        sample <= ~quarter[mirror_idx_q[QUARTER_BITS-1:0]];
      end else begin
        sample <= quarter[mirror_idx_q[QUARTER_BITS-1:0]];
      end
    end
  end

endmodule

// ==== rtl/dds_channel.sv ====
// ------------------
// one DDS channel: accumulator, parallel lookups,
// valid tracking and output stall
// ------------------
`timescale 1ns/1ps
`include "dds_defines.svh"

module dds_channel
  import dds_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      phase_inc_valid,
  input  phase_t    phase_inc,
  input  logic      out_ready,
  output chan_out_t out
);

  localparam int LAST = `DDS_PIPE_DEPTH - 1;

  // one bit per stage, bit 0 is the phase register, top bit the output
  logic [`DDS_PIPE_DEPTH-1:0] stage_valid;

  // whole pipeline moves or whole pipeline holds
  logic pipe_en;

  phase_t  phases  [`DDS_PARALLEL];
  sample_t samples [`DDS_PARALLEL];

  // advance when the output register is empty or is being taken
  assign pipe_en = ~stage_valid[LAST] | out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      stage_valid <= '0;
    end else if (pipe_en) begin
      // the accumulator always has a word ready to enter
      stage_valid <= {stage_valid[LAST-1:0], 1'b1};
    end
  end

  dds_phase_accum i_accum (
    .clk             (clk),
    .reset           (reset),
    .phase_inc_valid (phase_inc_valid),
    .phase_inc       (phase_inc),
    .advance         (pipe_en),
    .phases          (phases)
  );

  // one table per sample so a full word is looked up each cycle
  for (genvar j = 0; j < `DDS_PARALLEL; j++) begin : g_lut
    dds_cos_lut i_lut (
      .clk    (clk),
      .enable (pipe_en),
      .phase  (phases[j]),
      .sample (samples[j])
    );
  end

  // lut outputs are the output register, only packing here
  always_comb begin
    out.valid = stage_valid[LAST];
    for (int j = 0; j < `DDS_PARALLEL; j++) begin
      out.word.samples[j] = samples[j];
    end
  end

endmodule

// ==== rtl/dds_multichannel.sv ====
// ------------------
// multichannel DDS top level
// ------------------
`timescale 1ns/1ps
`include "dds_defines.svh"

module dds_multichannel
  import dds_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      phase_inc_valid,
  input  phase_inc_t                phase_inc,
  input  logic [`DDS_CHANNELS-1:0]  out_ready,
  output chan_out_t                 chan_out [`DDS_CHANNELS]
);

  // a single valid loads every channel's increment at once,
  // each channel then stalls on its own ready
  for (genvar c = 0; c < `DDS_CHANNELS; c++) begin : g_chan
    dds_channel i_channel (
      .clk             (clk),
      .reset           (reset),
      .phase_inc_valid (phase_inc_valid),
      .phase_inc       (phase_inc.inc[c]),
      .out_ready       (out_ready[c]),
      .out             (chan_out[c])
    );
  end

endmodule

// ==== tests/dds_props.sv ====
// --------------------
// handshake and reset assertions for the DDS outputs
// --------------------
`timescale 1ns/1ps
`include "dds_defines.svh"

module dds_props
  import dds_pkg::*;
(
  input logic                     clk,
  input logic                     reset,
  input logic [`DDS_CHANNELS-1:0] out_ready,
  input chan_out_t                chan_out [`DDS_CHANNELS]
);

  for (genvar c = 0; c < `DDS_CHANNELS; c++) begin : g_chan

    // valid low in the cycle after any reset cycle
    a_reset_low: assert property (@(posedge clk) reset |=> !chan_out[c].valid)
      else $error("channel %0d valid high right after a reset cycle", c);

    // and still low one cycle after reset is released
    a_fill_low: assert property (@(posedge clk) $fell(reset) |=> !chan_out[c].valid)
      else $error("channel %0d valid high on the first cycle after reset", c);

    // a pending word is not withdrawn
    a_valid_held: assert property (@(posedge clk) disable iff (reset)
      chan_out[c].valid && !out_ready[c] |=> chan_out[c].valid)
      else $error("channel %0d dropped valid without a transfer", c);

    // and does not change while it waits
    a_word_stable: assert property (@(posedge clk) disable iff (reset)
      chan_out[c].valid && !out_ready[c] |=> $stable(chan_out[c].word))
      else $error("channel %0d word changed while stalled", c);

  end

endmodule

// ==== tests/dds_tb.sv ====
// --------------------
// DDS testbench with random stimulus, reference model and compare tasks
// --------------------
`timescale 1ns/1ps
`include "dds_defines.svh"

module dds_tb
  import dds_pkg::*;
();

  localparam int CH = `DDS_CHANNELS;
  localparam int PAR = `DDS_PARALLEL;
  localparam int DEPTH = `DDS_PIPE_DEPTH;
  localparam int SEED = 14;
  localparam int ADDR_BITS = $bits(lut_addr_t);
  localparam int QUARTER = 2 ** (ADDR_BITS - 2);
  localparam real AMPL = (2.0 ** (`DDS_SAMPLE_WIDTH - 1)) - 0.5;
  localparam real PI = 3.14159265358979323846;
  localparam int HOLD_CYCLES = 60;

  // planned length of each test in cycles
  localparam int T1_CYCLES = 16;
  localparam int T2_CYCLES = 80;
  localparam int T3_CYCLES = 160;
  localparam int T4_CYCLES = 160;
  localparam int T5_CYCLES = 100;
  localparam int TIMEOUT_CYCLES =
    2 * (T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES + T5_CYCLES);

  logic       clk;
  logic       reset;
  logic       phase_inc_valid;
  phase_inc_t phase_inc;
  logic [CH-1:0] out_ready;
  chan_out_t  chan_out [CH];

  // model state per channel
  phase_t m_base [CH];
  phase_t m_inc [CH];
  phase_t m_prev [CH];
  phase_t base_at_load [CH];
  int     old_left [CH];
  int     n_new [CH];
  int     rx_count [CH];
  bit     first_seen [CH];

  int errors = 0;
  int checks = 0;
  int err_mark = 0;
  int test_num = 0;
  int cycle_count = 0;

  dds_multichannel i_dut (
    .clk             (clk),
    .reset           (reset),
    .phase_inc_valid (phase_inc_valid),
    .phase_inc       (phase_inc),
    .out_ready       (out_ready),
    .chan_out        (chan_out)
  );

  bind dds_multichannel dds_props i_props (
    .clk       (clk),
    .reset     (reset),
    .out_ready (out_ready),
    .chan_out  (chan_out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // cosine of the top phase bits with the negative half taken as the inverted magnitude
  function automatic sample_t cos_sample(input phase_t p);
    lut_addr_t a;
    real       c;
    int        m;
    a = p[`DDS_PHASE_BITS-1 -: ADDR_BITS];
    // cos is zero here, floor(-0.5) is -1
    if (a == lut_addr_t'(QUARTER) || a == lut_addr_t'(3 * QUARTER)) begin
      return '1;
    end
    c = $cos(2.0 * PI * real'(a) / real'(4 * QUARTER));
    if (c < 0.0) begin
      m = $rtoi($floor(-AMPL * c - 0.5));
      return ~sample_t'(m);
    end
    m = $rtoi($floor(AMPL * c - 0.5));
    return sample_t'(m);
  endfunction

  function automatic word_t expected_word(input phase_t base, input phase_t inc);
    word_t w;
    for (int j = 0; j < PAR; j++) begin
      w.samples[j] = cos_sample(base + phase_t'(j) * inc);
    end
    return w;
  endfunction

  // cos(0) gives full scale 2^17 - 1 in every sample
  function automatic word_t cos_zero_word();
    word_t w;
    for (int j = 0; j < PAR; j++) begin
      w.samples[j] = sample_t'(131071);
    end
    return w;
  endfunction

  // wide enough that 64 words sweep the full circle at least once
  function automatic phase_t random_inc();
    return phase_t'(32'h0001_0000 + ($urandom % 32'h0030_0000));
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_phase(input string name, input phase_t got, input phase_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // old increment words are accepted only until the first new one
  task automatic take_word(input int c, input word_t w);
    string name;
    word_t exp_old;
    name = $sformatf("chan_out[%0d].word", c);
    if (!first_seen[c]) begin
      first_seen[c] = 1'b1;
      check_word(name, w, cos_zero_word());
    end
    exp_old = expected_word(m_base[c], m_prev[c]);
    if (old_left[c] > 0 && w == exp_old) begin
      m_base[c] = m_base[c] + phase_t'(PAR) * m_prev[c];
      old_left[c]--;
    end else begin
      check_word(name, w, expected_word(m_base[c], m_inc[c]));
      m_base[c] = m_base[c] + phase_t'(PAR) * m_inc[c];
      old_left[c] = 0;
      n_new[c]++;
    end
    rx_count[c]++;
  endtask

  task automatic model_load(input phase_inc_t v);
    for (int c = 0; c < CH; c++) begin
      m_prev[c] = m_inc[c];
      m_inc[c] = v.inc[c];
      old_left[c] = DEPTH;
      base_at_load[c] = m_base[c];
      n_new[c] = 0;
    end
  endtask

  // with a full pipeline every word already generated with the old
  // increment comes out before the first new one
  task automatic check_continuity();
    phase_t exp;
    for (int c = 0; c < CH; c++) begin
      exp = base_at_load[c] + phase_t'(DEPTH * PAR) * m_prev[c]
          + phase_t'(n_new[c] * PAR) * m_inc[c];
      check_phase($sformatf("base[%0d]", c), m_base[c], exp);
    end
  endtask

  // monitor takes the transfers of an edge before its increment load
  always @(posedge clk) begin
    if (reset) begin
      for (int c = 0; c < CH; c++) begin
        if (chan_out[c].valid) begin
          $display("error: channel %0d has valid high while reset is high", c);
          errors++;
        end
        m_base[c] = '0;
        m_inc[c] = '0;
        m_prev[c] = '0;
        base_at_load[c] = '0;
        old_left[c] = 0;
        n_new[c] = 0;
        first_seen[c] = 1'b0;
      end
    end else begin
      for (int c = 0; c < CH; c++) begin
        if (chan_out[c].valid && out_ready[c]) begin
          take_word(c, chan_out[c].word);
        end
      end
      if (phase_inc_valid) begin
        model_load(phase_inc);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic pulse_increments();
    phase_inc_t v;
    for (int c = 0; c < CH; c++) begin
      v.inc[c] = random_inc();
    end
    @(posedge clk);
    phase_inc <= v;
    phase_inc_valid <= 1'b1;
    @(posedge clk);
    phase_inc_valid <= 1'b0;
  endtask

  task automatic wait_words(input int n, input bit random_ready);
    int target [CH];
    bit done;
    @(negedge clk);
    for (int c = 0; c < CH; c++) begin
      target[c] = rx_count[c] + n;
    end
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      if (random_ready) begin
        out_ready <= CH'($urandom);
      end
      @(negedge clk);
      done = 1'b1;
      for (int c = 0; c < CH; c++) begin
        if (rx_count[c] < target[c]) begin
          done = 1'b0;
        end
      end
    end
  endtask

  task automatic end_test(input string name);
    test_num++;
    $display("test %0d (%s) finished with %0d errors", test_num, name, errors - err_mark);
    err_mark = errors;
  endtask

  initial begin
    int held_before;
    int run_before;
    void'($urandom(SEED));
    reset = 1'b1;
    phase_inc_valid = 1'b0;
    phase_inc = '0;
    out_ready = '1;
    for (int c = 0; c < CH; c++) begin
      rx_count[c] = 0;
    end

    repeat (5) @(posedge clk);
    reset <= 1'b0;
    wait_words(1, 1'b0);
    end_test("reset and first word");

    pulse_increments();
    wait_words(64 + DEPTH, 1'b0);
    check_continuity();
    end_test("fixed increments");

    wait_words(64, 1'b1);
    check_continuity();
    end_test("random back-pressure");

    wait_words(8, 1'b1);
    pulse_increments();
    wait_words(24, 1'b1);
    check_continuity();
    // second load while channel 0 is stalled
    @(posedge clk);
    out_ready <= CH'(2);
    repeat (3) @(posedge clk);
    pulse_increments();
    wait_words(24, 1'b1);
    check_continuity();
    end_test("increment change in flight");

    held_before = rx_count[1];
    run_before = rx_count[0];
    repeat (HOLD_CYCLES) begin
      @(posedge clk);
      out_ready <= CH'(1);
    end
    @(negedge clk);
    if (rx_count[1] - held_before > 1) begin
      $display("error: channel 1 kept delivering words while its ready was low");
      errors++;
    end
    if (rx_count[0] - run_before < HOLD_CYCLES - 4) begin
      $display("error: channel 0 slowed down while channel 1 was held");
      errors++;
    end
    @(posedge clk);
    out_ready <= '1;
    wait_words(16, 1'b0);
    end_test("independent channels");

    $display("%0d tests, %0d words checked, %0d errors", test_num, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== dds.f ====
+incdir+rtl
rtl/dds_pkg.sv
rtl/dds_phase_accum.sv
rtl/dds_cos_lut.sv
rtl/dds_channel.sv
rtl/dds_multichannel.sv
tests/dds_props.sv
tests/dds_tb.sv

// ==== Makefile ====
# Verilator build and run for the multichannel DDS testbench

VERILATOR ?= verilator
TOP       ?= dds_tb
FILELIST  ?= dds.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= FAIL: see errors above
PASS_MSG  ?= PASS: all tests

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(FILELIST) $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides, a run that stops before the closing line also fails
run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
